//--- rtl/matcalc_pkg.sv
// Shared sizes, element types and operation codes for the matrix calculator.
// Every RTL module and the testbench pull these in by wildcard import.
// Elements are stored at 8 bits and all results are produced at 16 bits.

package matcalc_pkg;

  // ==================================================
  // Storage geometry
  // ==================================================

  // Stored matrices, oldest one overwritten when full
  localparam int MAT_SLOTS = 4;
  localparam int SLOT_W    = 2;

  // Rows and columns run 1 to MAX_DIM
  localparam int MAX_DIM = 3;
  localparam int DIM_W   = 2;

  // ==================================================
  // Data widths
  // ==================================================

  localparam int ELEM_W = 8;
  localparam int RES_W  = 16;

  // Cycle counter for the performance readout
  localparam int CNT_W = 16;

  // Signed matrix element as held in storage
  typedef logic signed [ELEM_W-1:0] elem_t;

  // Result element, also used as the dot product accumulator
  typedef logic signed [RES_W-1:0] res_t;

  // Row or column count, or an index inside a matrix
  typedef logic [DIM_W-1:0] dim_t;

  // Index of a storage slot
  typedef logic [SLOT_W-1:0] slot_t;

  // ==================================================
  // Operations
  // ==================================================

  // Encoding matches the op_sel input pins
  typedef enum logic [1:0] {
    OP_ADD       = 2'd0,
    OP_SCALE     = 2'd1,
    OP_TRANSPOSE = 2'd2,
    OP_MULT      = 2'd3
  } op_code_t;

endpackage

//--- rtl/matcalc_ifs.sv
// Bundles used between the blocks of the matrix calculator.
// mat_wr_if carries entry writes, mat_rd_if is one combinational read port
// of the store, res_stream_if is the valid/ready element stream.
`timescale 1ns/1ns

// Decoder to store, single-cycle strobes
interface mat_wr_if import matcalc_pkg::*; ();
  logic  dims_we;
  dim_t  rows;
  dim_t  cols;
  logic  elem_we;
  dim_t  row;
  dim_t  col;
  elem_t data;
  logic  commit;

  modport source (output dims_we, rows, cols, elem_we, row, col, data, commit);
  modport sink   (input  dims_we, rows, cols, elem_we, row, col, data, commit);
endinterface

// ALU to store, answered in the same cycle
interface mat_rd_if import matcalc_pkg::*; ();
  slot_t slot;
  dim_t  row;
  dim_t  col;
  elem_t data;
  dim_t  rows;
  dim_t  cols;

  modport client (output slot, row, col, input  data, rows, cols);
  modport server (input  slot, row, col, output data, rows, cols);
endinterface

// Element stream, transfer on valid and ready
interface res_stream_if import matcalc_pkg::*; ();
  logic valid;
  res_t data;
  logic last_col;
  logic last;
  logic ready;

  modport source (output valid, data, last_col, last, input  ready);
  modport sink   (input  valid, data, last_col, last, output ready);
endinterface

//--- rtl/matrix_cmd_decode.sv
// Turns the entry byte stream into writes toward the matrix store.
// Format is a rows byte, a columns byte, then the elements in row-major order.
// Bad dimension bytes flag input_err for one cycle and restart the entry.
`timescale 1ns/1ns

module matrix_cmd_decode import matcalc_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx_valid,
  input  logic [7:0] rx_byte,
  mat_wr_if.source   wr,
  output logic       input_err
);

  typedef enum logic [1:0] {
    ST_ROWS,
    ST_COLS,
    ST_ELEMS
  } dec_state_t;

  dec_state_t state;

  // Shape of the matrix being entered
  dim_t rows_q;
  dim_t cols_q;

  // Position of the next element byte
  dim_t row_cnt;
  dim_t col_cnt;

  logic dim_legal;
  logic last_elem;

  // Dimension bytes 1 to MAX_DIM only
  assign dim_legal = (rx_byte != 8'd0) && (rx_byte <= 8'(MAX_DIM));
  assign last_elem = (row_cnt == rows_q - 2'd1) && (col_cnt == cols_q - 2'd1);

  // ==================================================
  // Write strobes, same cycle as the byte
  // ==================================================

  always_comb begin
    wr.dims_we = rx_valid && (state == ST_COLS) && dim_legal;
    wr.rows    = rows_q;
    // Columns come straight from the byte on the dims write
    wr.cols    = (state == ST_COLS) ? dim_t'(rx_byte[DIM_W-1:0]) : cols_q;
    wr.elem_we = rx_valid && (state == ST_ELEMS);
    wr.row     = row_cnt;
    wr.col     = col_cnt;
    wr.data    = elem_t'(rx_byte);
    wr.commit  = wr.elem_we && last_elem;
  end

  // ==================================================
  // Entry FSM
  // ==================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_ROWS;
      rows_q    <= '0;
      cols_q    <= '0;
      row_cnt   <= '0;
      col_cnt   <= '0;
      input_err <= 1'b0;
    end else begin
      // One-cycle error pulse per rejected byte
      input_err <= rx_valid && (state != ST_ELEMS) && !dim_legal;
      if (rx_valid) begin
        case (state)
          ST_ROWS: begin
            if (dim_legal) begin
              rows_q <= dim_t'(rx_byte[DIM_W-1:0]);
              state  <= ST_COLS;
            end
          end
          ST_COLS: begin
            // Bad column byte drops the whole entry
            if (dim_legal) begin
              cols_q  <= dim_t'(rx_byte[DIM_W-1:0]);
              row_cnt <= '0;
              col_cnt <= '0;
              state   <= ST_ELEMS;
            end else begin
              state <= ST_ROWS;
            end
          end
          default: begin
            if (last_elem) begin
              state <= ST_ROWS;
            end else if (col_cnt == cols_q - 2'd1) begin
              col_cnt <= '0;
              row_cnt <= row_cnt + 2'd1;
            end else begin
              col_cnt <= col_cnt + 2'd1;
            end
          end
        endcase
      end
    end
  end

endmodule

//--- rtl/matrix_store.sv
// Slot storage for up to four matrices with two combinational read ports.
// Elements land in the write pointer slot as they arrive; the shape of the
// slot changes only on commit, which also advances the pointer.
`timescale 1ns/1ns

module matrix_store import matcalc_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  mat_wr_if.sink     wr,
  mat_rd_if.server   rd_a,
  mat_rd_if.server   rd_b,
  output logic [2:0] matrix_count
);

  // Element array, no reset needed
  elem_t mem [MAT_SLOTS][MAX_DIM][MAX_DIM];

  // Committed shape per slot, zero means empty
  dim_t slot_rows [MAT_SLOTS];
  dim_t slot_cols [MAT_SLOTS];

  // Shape of the matrix still being entered
  dim_t  staged_rows;
  dim_t  staged_cols;
  slot_t wr_ptr;

  // ==================================================
  // Writes
  // ==================================================

  always_ff @(posedge clk) begin
    if (wr.elem_we) begin
      mem[wr_ptr][wr.row][wr.col] <= wr.data;
    end
    if (wr.dims_we) begin
      staged_rows <= wr.rows;
      staged_cols <= wr.cols;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr       <= '0;
      matrix_count <= '0;
      for (int s = 0; s < MAT_SLOTS; s++) begin
        slot_rows[s] <= '0;
        slot_cols[s] <= '0;
      end
    end else if (wr.commit) begin
      slot_rows[wr_ptr] <= staged_rows;
      slot_cols[wr_ptr] <= staged_cols;
      // Wraps onto the oldest slot
      wr_ptr <= wr_ptr + 2'd1;
      if (matrix_count != 3'(MAT_SLOTS)) begin
        matrix_count <= matrix_count + 3'd1;
      end
    end
  end

  // ==================================================
  // Read ports
  // ==================================================

  // Index 3 is outside the array, return zero there
  assign rd_a.data = (rd_a.row < MAX_DIM && rd_a.col < MAX_DIM) ?
                     mem[rd_a.slot][rd_a.row][rd_a.col] : '0;
  assign rd_a.rows = slot_rows[rd_a.slot];
  assign rd_a.cols = slot_cols[rd_a.slot];

  assign rd_b.data = (rd_b.row < MAX_DIM && rd_b.col < MAX_DIM) ?
                     mem[rd_b.slot][rd_b.row][rd_b.col] : '0;
  assign rd_b.rows = slot_rows[rd_b.slot];
  assign rd_b.cols = slot_cols[rd_b.slot];

endmodule

//--- rtl/matrix_alu.sv
// Execute unit. Latches the operation on an accepted start, checks the operand
// shapes one cycle later, then streams result elements in row-major order.
// Multiply accumulates one product per cycle over the columns of A.
`timescale 1ns/1ns

module matrix_alu import matcalc_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          start,
  input  op_code_t      op_sel,
  input  slot_t         id_a,
  input  slot_t         id_b,
  input  elem_t         scalar_val,
  mat_rd_if.client      rd_a,
  mat_rd_if.client      rd_b,
  res_stream_if.source  res,
  output logic          busy,
  output logic          err
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK,
    ST_RUN
  } alu_state_t;

  alu_state_t state;

  // Operation captured at start
  op_code_t op_q;
  slot_t    id_a_q;
  slot_t    id_b_q;
  elem_t    scalar_q;

  // Result shape minus one, and inner length for multiply
  dim_t rows_m1;
  dim_t cols_m1;
  dim_t k_m1;

  // Output row, output column, product term
  dim_t i_idx;
  dim_t j_idx;
  dim_t k_idx;
  res_t acc;

  logic err_q;
  logic dims_ok;
  logic k_done;
  logic last_elem;
  logic load_elem;
  res_t elem_val;
  res_t a_ext;
  res_t b_ext;

  // ==================================================
  // Operand addressing
  // ==================================================

  always_comb begin
    rd_a.slot = id_a_q;
    rd_b.slot = id_b_q;
    // Transpose reads A with row and column swapped
    rd_a.row  = (op_q == OP_TRANSPOSE) ? j_idx : i_idx;
    rd_a.col  = (op_q == OP_TRANSPOSE) ? i_idx : ((op_q == OP_MULT) ? k_idx : j_idx);
    rd_b.row  = (op_q == OP_MULT) ? k_idx : i_idx;
    rd_b.col  = j_idx;
  end

  // Shape check, an empty slot reads back as zero rows
  always_comb begin
    case (op_q)
      OP_ADD:  dims_ok = (rd_a.rows != '0) && (rd_b.rows != '0) &&
                         (rd_a.rows == rd_b.rows) && (rd_a.cols == rd_b.cols);
      OP_MULT: dims_ok = (rd_a.rows != '0) && (rd_b.rows != '0) &&
                         (rd_a.cols == rd_b.rows);
      default: dims_ok = (rd_a.rows != '0);
    endcase
  end

  // ==================================================
  // Element arithmetic at result width
  // ==================================================

  assign a_ext = res_t'(rd_a.data);
  assign b_ext = res_t'(rd_b.data);

  always_comb begin
    case (op_q)
      OP_ADD:       elem_val = a_ext + b_ext;
      OP_SCALE:     elem_val = a_ext * res_t'(scalar_q);
      OP_TRANSPOSE: elem_val = a_ext;
      default:      elem_val = acc + a_ext * b_ext;
    endcase
  end

  assign k_done    = (op_q != OP_MULT) || (k_idx == k_m1);
  assign last_elem = (i_idx == rows_m1) && (j_idx == cols_m1);
  // Output slot free or emptying this cycle
  assign load_elem = (state == ST_RUN) && k_done && (!res.valid || res.ready);

  assign busy = (state != ST_IDLE) || res.valid;
  // Failure shows from the check cycle on
  assign err  = err_q || ((state == ST_CHECK) && !dims_ok);

  // ==================================================
  // Control
  // ==================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      err_q     <= 1'b0;
      res.valid <= 1'b0;
      i_idx     <= '0;
      j_idx     <= '0;
      k_idx     <= '0;
      acc       <= '0;
    end else begin
      if (res.ready) begin
        res.valid <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          if (start) begin
            err_q <= 1'b0;
            state <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          i_idx <= '0;
          j_idx <= '0;
          k_idx <= '0;
          acc   <= '0;
          if (dims_ok) begin
            state <= ST_RUN;
          end else begin
            err_q <= 1'b1;
            state <= ST_IDLE;
          end
        end
        default: begin
          if (!k_done) begin
            // Product terms keep summing while the output is stalled
            acc   <= elem_val;
            k_idx <= k_idx + 2'd1;
          end else if (load_elem) begin
            res.valid <= 1'b1;
            acc       <= '0;
            k_idx     <= '0;
            if (last_elem) begin
              state <= ST_IDLE;
            end else if (j_idx == cols_m1) begin
              j_idx <= '0;
              i_idx <= i_idx + 2'd1;
            end else begin
              j_idx <= j_idx + 2'd1;
            end
          end
        end
      endcase
    end
  end

  // ==================================================
  // Operation and payload registers
  // ==================================================

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      op_q     <= op_sel;
      id_a_q   <= id_a;
      id_b_q   <= id_b;
      scalar_q <= scalar_val;
    end
    if (state == ST_CHECK) begin
      rows_m1 <= (op_q == OP_TRANSPOSE) ? rd_a.cols - 2'd1 : rd_a.rows - 2'd1;
      cols_m1 <= (op_q == OP_TRANSPOSE) ? rd_a.rows - 2'd1 :
                 ((op_q == OP_MULT) ? rd_b.cols - 2'd1 : rd_a.cols - 2'd1);
      k_m1    <= rd_a.cols - 2'd1;
    end
    if (load_elem) begin
      res.data     <= elem_val;
      res.last_col <= (j_idx == cols_m1);
      res.last     <= last_elem;
    end
  end

endmodule

//--- rtl/matrix_result_out.sv
// Output register for the result stream plus the operation cycle counter.
// Holds one element; accepts the next while the current one leaves.
// cycle_cnt runs from the accepted start to the last transfer and then holds.
`timescale 1ns/1ns

module matrix_result_out import matcalc_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             start_accepted,
  res_stream_if.sink       res,
  output logic             res_valid,
  output res_t             res_data,
  output logic             res_last_col,
  output logic             res_last,
  input  logic             res_ready,
  output logic [CNT_W-1:0] cycle_cnt
);

  logic counting;
  logic take;

  // Room when empty or being emptied now
  assign res.ready = !res_valid || res_ready;
  assign take      = res.valid && res.ready;

  // ==================================================
  // Output slot
  // ==================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else if (take) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      res_data     <= res.data;
      res_last_col <= res.last_col;
      res_last     <= res.last;
    end
  end

  // ==================================================
  // Cycle counter
  // ==================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      counting  <= 1'b0;
      cycle_cnt <= '0;
    end else if (start_accepted) begin
      counting  <= 1'b1;
      cycle_cnt <= '0;
    end else if (counting) begin
      cycle_cnt <= cycle_cnt + 1'b1;
      // Stops on the final element leaving the top level
      if (res_valid && res_ready && res_last) begin
        counting <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/matrix_calc_top.sv
// Top level of the matrix calculator core.
// Entry bytes go through the decoder into the store; a start pulse runs the
// ALU, whose elements leave through the registered valid/ready result port.
`timescale 1ns/1ns

module matrix_calc_top import matcalc_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             rx_valid,
  input  logic [7:0]       rx_byte,
  input  logic             start,
  input  op_code_t         op_sel,
  input  slot_t            id_a,
  input  slot_t            id_b,
  input  elem_t            scalar_val,
  input  logic             res_ready,
  output logic             res_valid,
  output res_t             res_data,
  output logic             res_last_col,
  output logic             res_last,
  output logic             busy,
  output logic             err,
  output logic             input_err,
  output logic [2:0]       matrix_count,
  output logic [CNT_W-1:0] cycle_cnt
);

  // ==================================================
  // Internal buses
  // ==================================================

  mat_wr_if     wr ();
  mat_rd_if     rd_a ();
  mat_rd_if     rd_b ();
  res_stream_if res_bus ();

  logic alu_busy;
  logic start_accepted;

  // Busy until the last element has left the output register
  assign busy           = alu_busy || res_valid;
  // Starts while busy are dropped here and nowhere else
  assign start_accepted = start && !busy;

  matrix_cmd_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .wr        (wr.source),
    .input_err (input_err)
  );

  matrix_store u_store (
    .clk          (clk),
    .reset        (reset),
    .wr           (wr.sink),
    .rd_a         (rd_a.server),
    .rd_b         (rd_b.server),
    .matrix_count (matrix_count)
  );

  matrix_alu u_alu (
    .clk        (clk),
    .reset      (reset),
    .start      (start_accepted),
    .op_sel     (op_sel),
    .id_a       (id_a),
    .id_b       (id_b),
    .scalar_val (scalar_val),
    .rd_a       (rd_a.client),
    .rd_b       (rd_b.client),
    .res        (res_bus.source),
    .busy       (alu_busy),
    .err        (err)
  );

  matrix_result_out u_result (
    .clk            (clk),
    .reset          (reset),
    .start_accepted (start_accepted),
    .res            (res_bus.sink),
    .res_valid      (res_valid),
    .res_data       (res_data),
    .res_last_col   (res_last_col),
    .res_last       (res_last),
    .res_ready      (res_ready),
    .cycle_cnt      (cycle_cnt)
  );

endmodule

//--- tests/tb_matrix_calc_asserts.sv
// Concurrent checks on the result port and status flags of the core.
// Bound into matrix_calc_top, so it watches the top-level ports directly.
`timescale 1ns/1ns

module tb_matrix_calc_asserts import matcalc_pkg::*; (
  input logic clk,
  input logic reset,
  input logic res_valid,
  input logic res_ready,
  input res_t res_data,
  input logic res_last_col,
  input logic res_last,
  input logic busy,
  input logic err,
  input logic input_err
);

  // Payload frozen while the consumer stalls
  property hold_until_ready;
    @(posedge clk) disable iff (reset)
      res_valid && !res_ready |=> res_valid && $stable(res_data) &&
                                  $stable(res_last_col) && $stable(res_last);
  endproperty

  // All quiet right after a reset cycle
  property quiet_in_reset;
    @(posedge clk) reset |=> !res_valid && !err && !input_err && !busy;
  endproperty

  // One-cycle error pulse
  property input_err_single;
    @(posedge clk) disable iff (reset) input_err |=> !input_err;
  endproperty

  a_hold: assert property (hold_until_ready) else $error("result payload changed while stalled");
  a_reset: assert property (quiet_in_reset) else $error("outputs active during reset");
  a_ierr: assert property (input_err_single) else $error("input_err high for two cycles");

endmodule

bind matrix_calc_top tb_matrix_calc_asserts u_asserts (
  .clk          (clk),
  .reset        (reset),
  .res_valid    (res_valid),
  .res_ready    (res_ready),
  .res_data     (res_data),
  .res_last_col (res_last_col),
  .res_last     (res_last),
  .busy         (busy),
  .err          (err),
  .input_err    (input_err)
);

//--- tests/tb_matrix_calc.sv
// Testbench for the matrix calculator core.
// Enters random matrices, runs random operations and compares each result
// element, flag and count with a reference model kept here.
// Stimulus comes from $urandom with a fixed seed.
`timescale 1ns/1ns

module tb_matrix_calc import matcalc_pkg::*; ();

  localparam int TIMEOUT = 200;

  logic             clk;
  logic             reset;
  logic             rx_valid;
  logic [7:0]       rx_byte;
  logic             start;
  op_code_t         op_sel;
  slot_t            id_a;
  slot_t            id_b;
  elem_t            scalar_val;
  logic             res_ready;
  logic             res_valid;
  res_t             res_data;
  logic             res_last_col;
  logic             res_last;
  logic             busy;
  logic             err;
  logic             input_err;
  logic [2:0]       matrix_count;
  logic [CNT_W-1:0] cycle_cnt;

  // Reference model of the store
  elem_t model_mem [MAT_SLOTS][MAX_DIM][MAX_DIM];
  int    model_rows [MAT_SLOTS];
  int    model_cols [MAT_SLOTS];
  int    model_ptr;
  int    model_count;

  // Expected stream, row-major
  res_t exp_data [$];
  logic exp_lc [$];
  logic exp_last [$];

  logic backpressure;
  int   error_count;

  matrix_calc_top dut (
    .clk          (clk),
    .reset        (reset),
    .rx_valid     (rx_valid),
    .rx_byte      (rx_byte),
    .start        (start),
    .op_sel       (op_sel),
    .id_a         (id_a),
    .id_b         (id_b),
    .scalar_val   (scalar_val),
    .res_ready    (res_ready),
    .res_valid    (res_valid),
    .res_data     (res_data),
    .res_last_col (res_last_col),
    .res_last     (res_last),
    .busy         (busy),
    .err          (err),
    .input_err    (input_err),
    .matrix_count (matrix_count),
    .cycle_cnt    (cycle_cnt)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // ==================================================
  // Compare tasks
  // ==================================================

  task automatic stop_on_error(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_elem(input res_t got, input logic got_lc, input logic got_last,
                            input res_t want, input logic want_lc, input logic want_last);
    if (got !== want || got_lc !== want_lc || got_last !== want_last) begin
      stop_on_error($sformatf(
        "Error at %0t ns: element %0d lc %b last %b, expected %0d lc %b last %b",
        $time, got, got_lc, got_last, want, want_lc, want_last));
    end
  endtask

  task automatic check_count(input logic [2:0] got, input logic [2:0] want);
    if (got !== want) begin
      stop_on_error($sformatf("Error at %0t ns: matrix_count %0d, expected %0d",
                              $time, got, want));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      stop_on_error($sformatf("Error at %0t ns: %s is %b, expected %b", $time, name, got, want));
    end
  endtask

  task automatic check_cycles(input logic [CNT_W-1:0] got, input int min_cycles);
    if (got < min_cycles) begin
      stop_on_error($sformatf("Error at %0t ns: cycle_cnt %0d, expected at least %0d",
                              $time, got, min_cycles));
    end
  endtask

  // ==================================================
  // Stimulus helpers
  // ==================================================

  // Extremes now and then for overflow corners
  function automatic elem_t rand_elem();
    int pick;
    pick = $urandom % 8;
    if (pick == 0) return elem_t'(8'h80);
    if (pick == 1) return elem_t'(8'h7f);
    if (pick == 2) return elem_t'(8'h81);
    return elem_t'($urandom % 256);
  endfunction

  // Byte is consumed on the next rising edge
  task automatic send_byte(input logic [7:0] b);
    rx_valid <= 1'b1;
    rx_byte  <= b;
    @(posedge clk);
  endtask

  task automatic enter_matrix(input int rows, input int cols, output slot_t slot);
    elem_t v;
    slot = slot_t'(model_ptr);
    send_byte(8'(rows));
    send_byte(8'(cols));
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        v = rand_elem();
        model_mem[model_ptr][i][j] = v;
        send_byte(v);
      end
    end
    rx_valid <= 1'b0;
    model_rows[model_ptr] = rows;
    model_cols[model_ptr] = cols;
    // Oldest slot goes first once full
    model_ptr = (model_ptr + 1) % MAT_SLOTS;
    if (model_count < MAT_SLOTS) model_count++;
    @(posedge clk);
    check_count(matrix_count, 3'(model_count));
  endtask

  // Bad rows byte, or a legal rows byte then a bad columns byte
  task automatic reject_entry(input logic [7:0] first, input logic [7:0] second,
                              input logic two_bytes);
    send_byte(first);
    if (two_bytes) send_byte(second);
    rx_valid <= 1'b0;
    @(posedge clk);
    check_flag("input_err", input_err, 1'b1);
    @(posedge clk);
    check_flag("input_err", input_err, 1'b0);
    check_count(matrix_count, 3'(model_count));
  endtask

  // Fills the expected queues, ok low for a failed shape check
  task automatic build_expected(input op_code_t op, input slot_t a, input slot_t b,
                                input elem_t sc, output logic ok);
    int ra, ca, rb, cb, rows, cols, acc;
    ra = model_rows[a];
    ca = model_cols[a];
    rb = model_rows[b];
    cb = model_cols[b];
    exp_data.delete();
    exp_lc.delete();
    exp_last.delete();
    case (op)
      OP_ADD:  ok = (ra != 0) && (rb != 0) && (ra == rb) && (ca == cb);
      OP_MULT: ok = (ra != 0) && (rb != 0) && (ca == rb);
      default: ok = (ra != 0);
    endcase
    if (!ok) return;
    rows = (op == OP_TRANSPOSE) ? ca : ra;
    cols = (op == OP_TRANSPOSE) ? ra : ((op == OP_MULT) ? cb : ca);
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        case (op)
          OP_ADD:       acc = model_mem[a][i][j] + model_mem[b][i][j];
          OP_SCALE:     acc = model_mem[a][i][j] * sc;
          OP_TRANSPOSE: acc = model_mem[a][j][i];
          default: begin
            acc = 0;
            for (int k = 0; k < ca; k++) acc += model_mem[a][i][k] * model_mem[b][k][j];
          end
        endcase
        // 16-bit result wraps like the hardware
        exp_data.push_back(res_t'(acc));
        exp_lc.push_back(j == cols - 1);
        exp_last.push_back((i == rows - 1) && (j == cols - 1));
      end
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy) begin
      cycles++;
      if (cycles > TIMEOUT) stop_on_error("Timeout: busy stayed high while waiting for idle");
      @(posedge clk);
    end
  endtask

  task automatic run_op(input op_code_t op, input slot_t a, input slot_t b, input elem_t sc);
    logic ok;
    int   n;
    int   cycles;
    build_expected(op, a, b, sc, ok);
    n = exp_data.size();
    wait_idle();
    start      <= 1'b1;
    op_sel     <= op;
    id_a       <= a;
    id_b       <= b;
    scalar_val <= sc;
    @(posedge clk);
    start <= 1'b0;
    // Shape check result shows one cycle after the start
    @(posedge clk);
    check_flag("err", err, !ok);
    check_flag("busy", busy, 1'b1);
    cycles = 0;
    while (busy) begin
      if (res_valid && !ok) stop_on_error("Result element appeared for an invalid operation");
      if (res_valid && res_ready) begin
        if (exp_data.size() == 0) stop_on_error("Extra result element beyond the expected count");
        check_elem(res_data, res_last_col, res_last,
                   exp_data.pop_front(), exp_lc.pop_front(), exp_last.pop_front());
      end
      res_ready <= backpressure ? (($urandom % 2) == 0) : 1'b1;
      cycles++;
      if (cycles > TIMEOUT) stop_on_error("Timeout: operation did not finish");
      @(posedge clk);
    end
    // A rejected start frees the core two cycles after it
    if (!ok && cycles != 1) stop_on_error("busy did not fall two cycles after a rejected start");
    if (exp_data.size() != 0) stop_on_error("Result stream ended with elements missing");
    check_flag("err", err, !ok);
    if (ok) check_cycles(cycle_cnt, n);
    res_ready <= 1'b1;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    slot_t    s0, s1, s2;
    slot_t    sa, sb;
    op_code_t op;
    clk          = 1'b0;
    reset        = 1'b1;
    rx_valid     = 1'b0;
    rx_byte      = 8'd0;
    start        = 1'b0;
    op_sel       = OP_ADD;
    id_a         = '0;
    id_b         = '0;
    scalar_val   = '0;
    res_ready    = 1'b1;
    backpressure = 1'b0;
    error_count  = 0;
    model_ptr    = 0;
    model_count  = 0;
    for (int s = 0; s < MAT_SLOTS; s++) begin
      model_rows[s] = 0;
      model_cols[s] = 0;
    end
    void'($urandom(9));

    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_count(matrix_count, 3'd0);
    check_flag("err", err, 1'b0);
    check_flag("input_err", input_err, 1'b0);

    // Nothing stored yet
    run_op(OP_ADD, 2'd0, 2'd1, 8'sd0);
    run_op(OP_TRANSPOSE, 2'd2, 2'd0, 8'sd0);

    // Six entries, count saturates at 4
    repeat (6) enter_matrix(1 + $urandom % MAX_DIM, 1 + $urandom % MAX_DIM, sa);

    // Add, scale, transpose at full rate
    repeat (24) begin
      sa = slot_t'($urandom % MAT_SLOTS);
      sb = (($urandom % 2) == 0) ? sa : slot_t'($urandom % MAT_SLOTS);
      op = op_code_t'($urandom % 3);
      run_op(op, sa, sb, rand_elem());
    end

    // Known shapes for multiply and the mismatch cases
    enter_matrix(3, 2, s0);
    enter_matrix(2, 3, s1);
    run_op(OP_MULT, s0, s1, 8'sd0);
    run_op(OP_MULT, s1, s0, 8'sd0);
    run_op(OP_ADD, s0, s1, 8'sd0);
    run_op(OP_MULT, s0, s0, 8'sd0);
    run_op(OP_MULT, s1, s0, 8'sd0);
    enter_matrix(3, 3, s2);
    run_op(OP_MULT, s2, s2, 8'sd0);
    repeat (16) begin
      run_op(OP_MULT, slot_t'($urandom % MAT_SLOTS), slot_t'($urandom % MAT_SLOTS), 8'sd0);
    end

    // Random stalls on the output
    backpressure = 1'b1;
    repeat (24) begin
      sa = slot_t'($urandom % MAT_SLOTS);
      sb = (($urandom % 2) == 0) ? sa : slot_t'($urandom % MAT_SLOTS);
      run_op(op_code_t'($urandom % 4), sa, sb, rand_elem());
    end
    backpressure = 1'b0;

    // Bad dimension bytes leave the store alone
    reject_entry(8'd0, 8'd0, 1'b0);
    reject_entry(8'd4, 8'd0, 1'b0);
    reject_entry(8'd2, 8'd0, 1'b1);
    reject_entry(8'd1, 8'hff, 1'b1);
    for (int s = 0; s < MAT_SLOTS; s++) run_op(OP_TRANSPOSE, slot_t'(s), slot_t'(s), 8'sd0);
    enter_matrix(3, 3, s2);
    run_op(OP_SCALE, s2, s2, rand_elem());

    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- build.f
rtl/matcalc_pkg.sv
rtl/matcalc_ifs.sv
rtl/matrix_cmd_decode.sv
rtl/matrix_store.sv
rtl/matrix_alu.sv
rtl/matrix_result_out.sv
rtl/matrix_calc_top.sv
tests/tb_matrix_calc_asserts.sv
tests/tb_matrix_calc.sv

//--- Makefile
# Verilator build and run of the matrix calculator testbench

VERILATOR  ?= verilator
TOP        := tb_matrix_calc
FILELIST   := build.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
